//--- design/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Machine word width
`define RV_XLEN 32

// First instruction address
`define RV_PC_INIT 32'h0000_0000

// Cycles a memory access may wait before the core gives up
`define RV_MEM_TIMEOUT 16

`endif

//--- design/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    HALT
  } core_state_e;

  typedef struct packed {
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] imm;
    alu_op_e             alu_op;
    logic                uses_imm;
    logic                reg_write;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                branch_ne;
    logic                is_jal;
    logic                is_ebreak;
    logic                illegal;
  } decoded_t;

endpackage

//--- design/rv_bus_if.sv
`timescale 1ns/10ps
`include "rv_config.svh"

interface rv_bus_if;

  logic                req;
  logic                we;
  logic [`RV_XLEN-1:0] addr;
  logic [`RV_XLEN-1:0] wdata;
  logic                gnt;
  logic                rvalid;
  logic [`RV_XLEN-1:0] rdata;

  modport requester (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  // Response side driven by the memory arbiter
  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- design/rv_control_fsm.sv
`timescale 1ns/10ps

module rv_control_fsm (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pkg::decoded_t     dec_i,
  input  logic                 timeout_i,
  rv_bus_if.requester          fetch_bus,
  rv_bus_if.requester          lsu_bus,
  output rv_pkg::core_state_e  state_o,
  output logic                 retire_valid_o,
  output logic                 halted_o,
  output logic                 error_o
);
  import rv_pkg::*;

  core_state_e state_q;
  logic        req_q;
  logic        wait_q;
  logic        error_q;
  logic        gnt;
  logic        rvalid;

  // Only the bus that belongs to the current state is live
  assign gnt    = (state_q == MEMORY) ? lsu_bus.gnt : fetch_bus.gnt;
  assign rvalid = (state_q == MEMORY) ? lsu_bus.rvalid : fetch_bus.rvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH;
      req_q   <= 1'b0;
      wait_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      case (state_q)
        FETCH, MEMORY: begin
          if (timeout_i) begin
            state_q <= HALT;
            error_q <= 1'b1;
            req_q   <= 1'b0;
            wait_q  <= 1'b0;
          end else if (!req_q && !wait_q) begin
            // First fetch out of reset
            req_q <= 1'b1;
          end else if (req_q && gnt) begin
            req_q  <= 1'b0;
            wait_q <= 1'b1;
          end else if (wait_q && rvalid) begin
            wait_q  <= 1'b0;
            state_q <= (state_q == FETCH) ? DECODE : WRITEBACK;
          end
        end
        DECODE: begin
          if (dec_i.illegal) begin
            state_q <= HALT;
            error_q <= 1'b1;
          end else if (dec_i.is_ebreak) begin
            state_q <= HALT;
          end else begin
            state_q <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (dec_i.is_load || dec_i.is_store) begin
            state_q <= MEMORY;
            req_q   <= 1'b1;
          end else begin
            state_q <= WRITEBACK;
          end
        end
        WRITEBACK: begin
          state_q <= FETCH;
          req_q   <= 1'b1;
        end
        default: state_q <= HALT;
      endcase
    end
  end

  assign fetch_bus.req = req_q && (state_q == FETCH);
  assign fetch_bus.we  = 1'b0;
  assign lsu_bus.req   = req_q && (state_q == MEMORY);
  assign lsu_bus.we    = dec_i.is_store;

  assign state_o        = state_q;
  assign retire_valid_o = (state_q == WRITEBACK);
  assign halted_o       = (state_q == HALT);
  assign error_o        = error_q;

endmodule

//--- design/rv_wait_timer.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_wait_timer (
  input  logic clk,
  input  logic rst,
  input  logic waiting_i,
  input  logic done_i,
  output logic timeout_o
);

  localparam int CNT_W = $clog2(`RV_MEM_TIMEOUT + 1);

  logic [CNT_W-1:0] cnt_q;

  // The current cycle counts as well, so fire one short of the limit
  assign timeout_o = waiting_i && !done_i && (cnt_q == CNT_W'(`RV_MEM_TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (done_i || !waiting_i || timeout_o) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

//--- design/rv_decoder.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                load_i,
  input  logic [31:0]         inst_i,
  output rv_pkg::decoded_t    dec_o
);
  import rv_pkg::*;

  logic [31:0]         ir_q;
  opcode_e             opc;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir_q <= 32'h0000_0013;
    end else if (load_i) begin
      ir_q <= inst_i;
    end
  end

  assign opc    = opcode_e'(ir_q[6:0]);
  assign funct3 = ir_q[14:12];
  assign funct7 = ir_q[31:25];

  assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
  assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
  assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
  assign imm_u = {ir_q[31:12], 12'b0};
  assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

  always_comb begin
    dec_o        = '0;
    dec_o.rs1    = ir_q[19:15];
    dec_o.rs2    = ir_q[24:20];
    dec_o.rd     = ir_q[11:7];
    dec_o.alu_op = ALU_ADD;
    case (opc)
      OPC_OP: begin
        dec_o.reg_write = 1'b1;
        if (funct7 == 7'b0100000 && funct3 == 3'b000) dec_o.alu_op = ALU_SUB;
        else if (funct7 == 7'b0 && funct3 == 3'b000) dec_o.alu_op = ALU_ADD;
        else if (funct7 == 7'b0 && funct3 == 3'b100) dec_o.alu_op = ALU_XOR;
        else if (funct7 == 7'b0 && funct3 == 3'b110) dec_o.alu_op = ALU_OR;
        else if (funct7 == 7'b0 && funct3 == 3'b111) dec_o.alu_op = ALU_AND;
        else dec_o.illegal = 1'b1;
      end
      OPC_OP_IMM: begin
        // ADDI only
        dec_o.imm       = imm_i;
        dec_o.uses_imm  = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.illegal   = (funct3 != 3'b000);
      end
      OPC_LUI: begin
        dec_o.imm       = imm_u;
        dec_o.uses_imm  = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.alu_op    = ALU_PASS_B;
      end
      OPC_LOAD: begin
        dec_o.imm       = imm_i;
        dec_o.uses_imm  = 1'b1;
        dec_o.reg_write = 1'b1;
        dec_o.is_load   = 1'b1;
        dec_o.illegal   = (funct3 != 3'b010);
      end
      OPC_STORE: begin
        dec_o.imm      = imm_s;
        dec_o.uses_imm = 1'b1;
        dec_o.is_store = 1'b1;
        dec_o.illegal  = (funct3 != 3'b010);
      end
      OPC_BRANCH: begin
        dec_o.imm       = imm_b;
        dec_o.is_branch = 1'b1;
        dec_o.branch_ne = (funct3 == 3'b001);
        dec_o.illegal   = (funct3[2:1] != 2'b00);
      end
      OPC_JAL: begin
        dec_o.imm       = imm_j;
        dec_o.reg_write = 1'b1;
        dec_o.is_jal    = 1'b1;
      end
      OPC_SYSTEM: begin
        dec_o.is_ebreak = (ir_q == 32'h0010_0073);
        dec_o.illegal   = (ir_q != 32'h0010_0073);
      end
      default: dec_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic                we_i,
  input  logic [4:0]          waddr_i,
  input  logic [4:0]          raddr1_i,
  input  logic [4:0]          raddr2_i,
  input  logic [`RV_XLEN-1:0] wdata_i,
  output logic [`RV_XLEN-1:0] rdata1_o,
  output logic [`RV_XLEN-1:0] rdata2_o
);

  logic [`RV_XLEN-1:0] regs_q [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 is cleared on reset and never written
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

//--- design/rv_exec.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_exec (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_pkg::core_state_e  state_i,
  input  rv_pkg::decoded_t     dec_i,
  input  logic [`RV_XLEN-1:0]  rs1_i,
  input  logic [`RV_XLEN-1:0]  rs2_i,
  input  logic [`RV_XLEN-1:0]  load_data_i,
  output logic [`RV_XLEN-1:0]  pc_o,
  output logic [`RV_XLEN-1:0]  mem_addr_o,
  output logic [`RV_XLEN-1:0]  mem_wdata_o,
  output logic [`RV_XLEN-1:0]  wb_data_o,
  output logic                 wb_en_o
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] alu_q;
  logic [`RV_XLEN-1:0] load_q;
  logic                taken_q;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_res;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] next_pc;

  assign op_b = dec_i.uses_imm ? dec_i.imm : rs2_i;

  always_comb begin
    case (dec_i.alu_op)
      ALU_SUB:    alu_res = rs1_i - op_b;
      ALU_AND:    alu_res = rs1_i & op_b;
      ALU_OR:     alu_res = rs1_i | op_b;
      ALU_XOR:    alu_res = rs1_i ^ op_b;
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = rs1_i + op_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (state_i == EXECUTE) begin
      alu_q   <= alu_res;
      taken_q <= dec_i.is_branch && ((rs1_i == rs2_i) ^ dec_i.branch_ne);
    end
    // Last MEMORY cycle is the one carrying rvalid
    if (state_i == MEMORY) begin
      load_q <= load_data_i;
    end
  end

  assign pc_plus4 = pc_q + 32'd4;
  assign next_pc  = (dec_i.is_jal || taken_q) ? pc_q + dec_i.imm : pc_plus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= `RV_PC_INIT;
    end else if (state_i == WRITEBACK) begin
      pc_q <= next_pc;
    end
  end

  assign pc_o        = pc_q;
  assign mem_addr_o  = alu_q;
  assign mem_wdata_o = rs2_i;

  always_comb begin
    if (dec_i.is_jal) wb_data_o = pc_plus4;
    else if (dec_i.is_load) wb_data_o = load_q;
    else wb_data_o = alu_q;
  end

  assign wb_en_o = (state_i == WRITEBACK) && dec_i.reg_write && (dec_i.rd != 5'd0);

endmodule

//--- design/rv_mem_arbiter.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_mem_arbiter (
  input  logic                clk,
  input  logic                rst,
  rv_bus_if.arbiter           fetch_bus,
  rv_bus_if.arbiter           lsu_bus,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [`RV_XLEN-1:0] mem_addr_o,
  output logic [`RV_XLEN-1:0] mem_wdata_o,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  logic [`RV_XLEN-1:0] mem_rdata_i
);

  // High while the load/store side owns the outstanding access
  logic lsu_owner_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      lsu_owner_q <= 1'b0;
    end else if (mem_gnt_i) begin
      lsu_owner_q <= lsu_bus.req;
    end
  end

  // Requests never overlap, so a plain select is enough
  assign mem_req_o   = fetch_bus.req | lsu_bus.req;
  assign mem_we_o    = lsu_bus.req ? lsu_bus.we : fetch_bus.we;
  assign mem_addr_o  = lsu_bus.req ? lsu_bus.addr : fetch_bus.addr;
  assign mem_wdata_o = lsu_bus.req ? lsu_bus.wdata : fetch_bus.wdata;

  assign fetch_bus.gnt = mem_gnt_i && fetch_bus.req;
  assign lsu_bus.gnt   = mem_gnt_i && lsu_bus.req;

  assign fetch_bus.rvalid = mem_rvalid_i && !lsu_owner_q;
  assign lsu_bus.rvalid   = mem_rvalid_i && lsu_owner_q;
  assign fetch_bus.rdata  = mem_rdata_i;
  assign lsu_bus.rdata    = mem_rdata_i;

endmodule

//--- design/rv_core.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core (
  input  logic                clk,
  input  logic                rst,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output logic [`RV_XLEN-1:0] mem_addr_o,
  output logic [`RV_XLEN-1:0] mem_wdata_o,
  input  logic                mem_gnt_i,
  input  logic                mem_rvalid_i,
  input  logic [`RV_XLEN-1:0] mem_rdata_i,
  output logic                retire_valid_o,
  output logic [`RV_XLEN-1:0] retire_pc_o,
  output logic [4:0]          retire_rd_o,
  output logic [`RV_XLEN-1:0] retire_wdata_o,
  output logic                halted_o,
  output logic                error_o
);
  import rv_pkg::*;

  decoded_t            dec;
  core_state_e         state;
  logic                timeout;
  logic                mem_wait;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] wb_data;
  logic                wb_en;

  rv_bus_if fetch_bus ();
  rv_bus_if lsu_bus ();

  // Address and store data come from the datapath
  assign fetch_bus.addr  = pc;
  assign fetch_bus.wdata = '0;

  assign mem_wait = (state == FETCH) || (state == MEMORY);

  rv_control_fsm i_control_fsm (
    .clk            (clk),
    .rst            (rst),
    .dec_i          (dec),
    .timeout_i      (timeout),
    .fetch_bus      (fetch_bus),
    .lsu_bus        (lsu_bus),
    .state_o        (state),
    .retire_valid_o (retire_valid_o),
    .halted_o       (halted_o),
    .error_o        (error_o)
  );

  rv_wait_timer i_wait_timer (
    .clk       (clk),
    .rst       (rst),
    .waiting_i (mem_wait),
    .done_i    (fetch_bus.rvalid | lsu_bus.rvalid),
    .timeout_o (timeout)
  );

  rv_decoder i_decoder (
    .clk    (clk),
    .rst    (rst),
    .load_i (fetch_bus.rvalid),
    .inst_i (fetch_bus.rdata),
    .dec_o  (dec)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .rst      (rst),
    .we_i     (wb_en),
    .waddr_i  (dec.rd),
    .raddr1_i (dec.rs1),
    .raddr2_i (dec.rs2),
    .wdata_i  (wb_data),
    .rdata1_o (rs1_data),
    .rdata2_o (rs2_data)
  );

  rv_exec i_exec (
    .clk         (clk),
    .rst         (rst),
    .state_i     (state),
    .dec_i       (dec),
    .rs1_i       (rs1_data),
    .rs2_i       (rs2_data),
    .load_data_i (lsu_bus.rdata),
    .pc_o        (pc),
    .mem_addr_o  (lsu_bus.addr),
    .mem_wdata_o (lsu_bus.wdata),
    .wb_data_o   (wb_data),
    .wb_en_o     (wb_en)
  );

  rv_mem_arbiter i_mem_arbiter (
    .clk          (clk),
    .rst          (rst),
    .fetch_bus    (fetch_bus),
    .lsu_bus      (lsu_bus),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  assign retire_pc_o    = pc;
  assign retire_rd_o    = wb_en ? dec.rd : 5'd0;
  assign retire_wdata_o = wb_data;

endmodule

//--- tests/rv_core_properties.sv
`timescale 1ns/10ps

module rv_core_properties (
  input logic clk,
  input logic rst,
  input logic mem_req_i,
  input logic mem_gnt_i,
  input logic retire_valid_i,
  input logic halted_i,
  input logic error_i
);

  // A timeout may drop the request without a grant
  req_holds: assert property (@(posedge clk) disable iff (rst)
    mem_req_i && !mem_gnt_i |=> mem_req_i || error_i)
    else $error("mem_req_o dropped before mem_gnt_i");

  no_req_halted: assert property (@(posedge clk) disable iff (rst)
    halted_i |-> !mem_req_i)
    else $error("mem_req_o raised while halted");

  retire_pulse: assert property (@(posedge clk) disable iff (rst)
    retire_valid_i |=> !retire_valid_i)
    else $error("retire_valid_o longer than one cycle");

  error_halts: assert property (@(posedge clk) disable iff (rst)
    error_i |-> halted_i)
    else $error("error_o without halted_o");

endmodule

bind rv_core rv_core_properties i_properties (
  .clk            (clk),
  .rst            (rst),
  .mem_req_i      (mem_req_o),
  .mem_gnt_i      (mem_gnt_i),
  .retire_valid_i (retire_valid_o),
  .halted_i       (halted_o),
  .error_i        (error_o)
);

//--- tests/rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_config.svh"

module rv_core_tb;

  localparam int          N_INST    = 200;
  localparam int          RUN_LIMIT = N_INST * 20;
  localparam logic [31:0] EBREAK    = 32'h0010_0073;
  localparam logic [11:0] DATA_BASE = 12'h400;

  typedef enum logic [1:0] {M_IDLE, M_GRANT, M_RESP, M_STALL} mem_state_e;

  logic        clk;
  logic        rst;
  logic        mem_req_o;
  logic        mem_we_o;
  logic [31:0] mem_addr_o;
  logic [31:0] mem_wdata_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_wdata_o;
  logic        halted_o;
  logic        error_o;

  logic [31:0] mem [1024];
  logic [31:0] ref_mem [1024];
  logic [31:0] ref_regs [32];
  logic [31:0] ref_pc;
  logic [31:0] lfsr;

  // Expected effects of the instruction now in flight
  logic [31:0] exp_pc;
  logic [4:0]  exp_rd;
  logic [31:0] exp_wdata;
  logic        exp_store;
  logic [31:0] exp_addr;
  logic [31:0] exp_data;
  logic        exp_halt;
  logic        exp_err;
  logic        store_seen;

  mem_state_e  mst;
  logic [1:0]  cnt;
  logic [31:0] acc_addr;
  logic        stall_en;
  logic [31:0] stall_addr;
  logic        err_seen;
  int          cyc;
  int          deadline;
  int          req_start;
  int          err_delay;
  int          mismatches;
  int          failures;
  int          retired;

  rv_core i_rv_core (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  task automatic put_word(input int idx, input logic [31:0] w);
    mem[idx]     = w;
    ref_mem[idx] = w;
  endtask

  task automatic clear_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i]     = (32'(i) * 32'h9E37_79B9) ^ 32'h5A5A_0000;
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc = `RV_PC_INIT;
  endtask

  task automatic gen_random_program();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [3:0]  kind;
    logic [11:0] off;
    logic [31:0] w;
    for (int i = 0; i < N_INST; i++) begin
      rd   = 5'(rand_bits(3));
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      kind = 4'(rand_bits(4));
      off  = DATA_BASE + {4'b0, 6'(rand_bits(6)), 2'b00};
      case (kind)
        4'd0, 4'd1, 4'd2: w = enc_i(12'(rand_bits(12)), rs1, 3'b000, rd, 7'h13);
        4'd3: w = enc_r(7'h00, rs2, rs1, 3'b000, rd);
        4'd4: w = enc_r(7'h20, rs2, rs1, 3'b000, rd);
        4'd5: w = enc_r(7'h00, rs2, rs1, 3'b111, rd);
        4'd6: w = enc_r(7'h00, rs2, rs1, 3'b110, rd);
        4'd7: w = enc_r(7'h00, rs2, rs1, 3'b100, rd);
        4'd8: w = {20'(rand_bits(20)), rd, 7'h37};
        4'd9, 4'd10: w = enc_i(off, 5'd0, 3'b010, rd, 7'h03);
        4'd11, 4'd12: w = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};
        // BEQ or BNE to +8
        4'd13, 4'd14: w = {7'b0, rs2, rs1, 2'b00, 1'(rand_bits(1)), 5'b01000, 7'h63};
        default: w = {1'b0, 10'd4, 1'b0, 8'd0, rd, 7'h6f};
      endcase
      put_word(i, w);
    end
    put_word(N_INST, EBREAK);
    put_word(N_INST + 1, EBREAK);
  endtask

  // ISA reference that executes the instruction at ref_pc
  task automatic model_step();
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] next;
    logic [31:0] addr;
    logic [4:0]  rd;
    logic        wr;
    inst      = ref_mem[ref_pc[11:2]];
    rd        = inst[11:7];
    a         = ref_regs[inst[19:15]];
    b         = ref_regs[inst[24:20]];
    next      = ref_pc + 32'd4;
    wr        = 1'b1;
    res       = '0;
    addr      = a + {{20{inst[31]}}, inst[31:20]};
    exp_pc    = ref_pc;
    exp_rd    = '0;
    exp_wdata = '0;
    exp_store = 1'b0;
    exp_halt  = 1'b0;
    exp_err   = 1'b0;
    case (inst[6:0])
      7'h13: res = addr;
      7'h33: begin
        case ({inst[30], inst[14:12]})
          4'b0000: res = a + b;
          4'b1000: res = a - b;
          4'b0100: res = a ^ b;
          4'b0110: res = a | b;
          4'b0111: res = a & b;
          default: exp_err = 1'b1;
        endcase
      end
      7'h37: res = {inst[31:12], 12'h000};
      7'h03: res = ref_mem[addr[11:2]];
      7'h23: begin
        wr        = 1'b0;
        exp_store = 1'b1;
        exp_addr  = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        exp_data  = b;
        ref_mem[exp_addr[11:2]] = b;
      end
      7'h63: begin
        wr = 1'b0;
        if ((a == b) != inst[12]) begin
          next = ref_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      7'h6f: begin
        res  = ref_pc + 32'd4;
        next = ref_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      7'h73: exp_halt = 1'b1;
      default: exp_err = 1'b1;
    endcase
    if (exp_err) begin
      exp_halt = 1'b1;
    end
    if (wr && !exp_halt && rd != 5'd0) begin
      exp_rd       = rd;
      exp_wdata    = res;
      ref_regs[rd] = res;
    end
    if (!exp_halt) begin
      ref_pc = next;
    end
  endtask

  task automatic check_retire();
    retired++;
    assert (!exp_halt) else begin
      $display("Halting instruction at pc %h retired", exp_pc);
      failures++;
    end
    assert (retire_pc_o == exp_pc) else begin
      $display("MISMATCH retire_pc_o: got %h expected %h", retire_pc_o, exp_pc);
      mismatches++;
    end
    assert (retire_rd_o == exp_rd) else begin
      $display("MISMATCH retire_rd_o: got %h expected %h", retire_rd_o, exp_rd);
      mismatches++;
    end
    if (exp_rd != 5'd0) begin
      assert (retire_wdata_o == exp_wdata) else begin
        $display("MISMATCH retire_wdata_o: got %h expected %h", retire_wdata_o, exp_wdata);
        mismatches++;
      end
    end
    assert (store_seen || !exp_store) else begin
      $display("Store at pc %h never reached memory", exp_pc);
      failures++;
    end
    store_seen = 1'b0;
    model_step();
  endtask

  task automatic grant_access();
    mem_gnt_i <= 1'b1;
    acc_addr  <= mem_addr_o;
    cnt       <= 2'(rand_bits(2));
    mst       <= M_RESP;
    if (mem_we_o) begin
      assert (exp_store) else begin
        $display("Unexpected store to address %h", mem_addr_o);
        failures++;
      end
      assert (mem_addr_o == exp_addr) else begin
        $display("MISMATCH mem_addr_o: got %h expected %h", mem_addr_o, exp_addr);
        mismatches++;
      end
      assert (mem_wdata_o == exp_data) else begin
        $display("MISMATCH mem_wdata_o: got %h expected %h", mem_wdata_o, exp_data);
        mismatches++;
      end
      store_seen = 1'b1;
      mem[mem_addr_o[11:2]] = mem_wdata_o;
    end
  endtask

  // Memory grants after 0 to 3 cycles and answers 1 to 4 cycles later
  always @(posedge clk) begin
    mem_gnt_i    <= 1'b0;
    mem_rvalid_i <= 1'b0;
    if (rst) begin
      mst <= M_IDLE;
    end else begin
      case (mst)
        M_IDLE: begin
          if (mem_req_o) begin
            if (stall_en && !mem_we_o && mem_addr_o == stall_addr) begin
              req_start = cyc;
              mst <= M_STALL;
            end else begin
              cnt = 2'(rand_bits(2));
              if (cnt == 2'd0) begin
                grant_access();
              end else begin
                cnt <= cnt - 2'd1;
                mst <= M_GRANT;
              end
            end
          end
        end
        M_GRANT: begin
          if (cnt == 2'd0) begin
            grant_access();
          end else begin
            cnt <= cnt - 2'd1;
          end
        end
        M_RESP: begin
          if (cnt == 2'd0) begin
            mem_rvalid_i <= 1'b1;
            mem_rdata_i  <= mem[acc_addr[11:2]];
            mst          <= M_IDLE;
          end else begin
            cnt <= cnt - 2'd1;
          end
        end
        default: mst <= M_STALL;
      endcase
    end
  end

  always @(posedge clk) begin
    if (!rst && retire_valid_o) begin
      check_retire();
    end
    if (!rst && error_o && !err_seen) begin
      err_seen  = 1'b1;
      err_delay = cyc - req_start;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > deadline) begin
      $display("Timeout: core did not halt within %0d cycles", RUN_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  task automatic start_run();
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    rst      <= 1'b0;
    deadline = cyc + RUN_LIMIT;
  endtask

  task automatic wait_halt_and_idle();
    while (!halted_o) @(posedge clk);
    repeat (20) begin
      @(posedge clk);
      assert (!mem_req_o && !retire_valid_o) else begin
        $display("Core requested memory or retired after it halted");
        failures++;
      end
    end
  endtask

  initial begin
    rst          = 1'b1;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    lfsr         = 32'h5921;
    stall_en     = 1'b0;
    stall_addr   = '0;
    err_seen     = 1'b0;
    store_seen   = 1'b0;
    cyc          = 0;
    deadline     = RUN_LIMIT;
    req_start    = 0;
    err_delay    = 0;
    mismatches   = 0;
    failures     = 0;
    retired      = 0;

    // Random program ending in EBREAK
    clear_memory();
    gen_random_program();
    model_step();
    start_run();
    wait_halt_and_idle();
    assert (!error_o) else begin
      $display("error_o is set after EBREAK");
      failures++;
    end
    assert (exp_halt && !exp_err) else begin
      $display("Core halted before it reached EBREAK");
      failures++;
    end

    // Illegal opcode as third word
    clear_memory();
    put_word(0, enc_i(12'd1, 5'd0, 3'b000, 5'd1, 7'h13));
    put_word(1, enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    put_word(2, 32'hFFFF_FFFF);
    put_word(3, EBREAK);
    model_step();
    start_run();
    wait_halt_and_idle();
    assert (error_o) else begin
      $display("error_o is not set after an illegal instruction");
      failures++;
    end
    assert (exp_err) else begin
      $display("Core halted before it reached the illegal word");
      failures++;
    end

    // Memory never grants the fourth fetch
    clear_memory();
    for (int i = 0; i < 4; i++) begin
      put_word(i, enc_i(12'(i + 1), 5'(i), 3'b000, 5'(i + 1), 7'h13));
    end
    put_word(4, EBREAK);
    stall_en   = 1'b1;
    stall_addr = 32'd12;
    model_step();
    start_run();
    // The error of the previous run stays visible until reset takes hold
    err_seen   = 1'b0;
    wait_halt_and_idle();
    assert (err_seen && error_o) else begin
      $display("error_o did not rise after the memory stopped answering");
      failures++;
    end
    assert (err_delay == `RV_MEM_TIMEOUT) else begin
      $display("MISMATCH error_o delay: got %h expected %h", err_delay, `RV_MEM_TIMEOUT);
      mismatches++;
    end

    $display("Summary: %0d retired, %0d mismatches, %0d other failures",
             retired, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+design
design/rv_pkg.sv
design/rv_bus_if.sv
design/rv_control_fsm.sv
design/rv_wait_timer.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_exec.sv
design/rv_mem_arbiter.sv
design/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

SRCS    := $(filter-out +%,$(shell cat project.f))
HEADERS := $(wildcard design/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): project.f $(SRCS) $(HEADERS)
	$(VERILATOR) --binary --assert --timing -Wno-fatal --top-module $(TOP) \
	  -Mdir $(OBJ_DIR) -f project.f

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@if grep -q "Errors found" $(LOG) || ! grep -q "No errors" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
